// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStageTb
FLAGS     ?= --binary --timing
OBJDIR    ?= obj_dir
PASSMSG   := All checks passed

SOURCES   := $(filter-out +%,$(shell cat compile.f))
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): compile.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f compile.f

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: compile.f
src/rvPkg.sv
src/decodeIf.sv
src/instFieldDecode.sv
src/immGen.sv
src/regFile.sv
src/writebackSelect.sv
src/decodeStage.sv
dv/tbClock.sv
dv/decodeStageTb.sv

// File: dv/decodeStageTb.sv
`timescale 1ns/1ns

module decodeStageTb;

    // ----------------------------------------------------------------------
    // Record layout, one word per field
    // ----------------------------------------------------------------------
    // 0 test, 1 inst, 2 wbRegWrite, 3 wbRdAddr, 4 wbSrc, 5 wbFunct3,
    // 6 aluResult, 7 memData, 8 pc4, 9 rdata1, 10 rdata2, 11 imm32,
    // 12 idWbSrc, 13 idRegWrite, 14 idIllegal
    localparam int RecWords     = 15;
    localparam int MaxRecs      = 64;
    localparam int ResetCycles  = 10;
    localparam int MarginCycles = 20;
    // Drive and sample points after the rising edge
    localparam int DriveDelay  = 10;
    localparam int SampleDelay = 80;

    logic [31:0] stim [0:MaxRecs*RecWords-1];

    logic                       clk;
    logic                       rst;
    logic [rvPkg::Xlen-1:0]     inst;
    logic                       wbRegWrite;
    logic [rvPkg::RegAddrW-1:0] wbRdAddr;
    rvPkg::wbSrcT               wbSrc;
    logic [rvPkg::Funct3W-1:0]  wbFunct3;
    logic [rvPkg::Xlen-1:0]     wbAluResult;
    logic [rvPkg::Xlen-1:0]     wbMemData;
    logic [rvPkg::Xlen-1:0]     wbPc4;
    logic [rvPkg::Xlen-1:0]     rdata1;
    logic [rvPkg::Xlen-1:0]     rdata2;
    logic [rvPkg::Xlen-1:0]     imm32;
    logic [rvPkg::Funct3W-1:0]  funct3;
    logic [rvPkg::Funct7W-1:0]  funct7;
    logic [rvPkg::RegAddrW-1:0] rs1Addr;
    logic [rvPkg::RegAddrW-1:0] rs2Addr;
    logic [rvPkg::RegAddrW-1:0] rdAddr;
    rvPkg::wbSrcT               idWbSrc;
    logic                       idRegWrite;
    logic                       idIllegal;

    // Bookkeeping
    int          errors;
    int          checks;
    int          testErrors;
    int          numRecs;
    int          cycles;
    int          cycleLimit;
    logic [31:0] curTest;

    tbClock uClock (
        .clk (clk),
        .rst (rst)
    );

    decodeStage u_dut (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .wbRegWrite  (wbRegWrite),
        .wbRdAddr    (wbRdAddr),
        .wbSrc       (wbSrc),
        .wbFunct3    (wbFunct3),
        .wbAluResult (wbAluResult),
        .wbMemData   (wbMemData),
        .wbPc4       (wbPc4),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm32       (imm32),
        .funct3      (funct3),
        .funct7      (funct7),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .rdAddr      (rdAddr),
        .idWbSrc     (idWbSrc),
        .idRegWrite  (idRegWrite),
        .idIllegal   (idIllegal)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("Mismatch %s in test %0d: got %h, expected %h", name, curTest, got, exp);
        end
    endtask

    // Records end at the first empty test number
    function automatic int countRecords();
        int n;
        n = 0;
        while (n < MaxRecs && !$isunknown(stim[n*RecWords]) && stim[n*RecWords] != 0) begin
            n++;
        end
        return n;
    endfunction

    // Bit field of an instruction word, lsb and width per the RV32I encoding
    function automatic logic [31:0] instField(input logic [31:0] word, input int lsb,
                                              input int width);
        logic [31:0] mask;
        mask = (32'h1 << width) - 32'h1;
        return (word >> lsb) & mask;
    endfunction

    task automatic applyRecord(input int base);
        inst        = stim[base+1];
        wbRegWrite  = stim[base+2][0];
        wbRdAddr    = stim[base+3][rvPkg::RegAddrW-1:0];
        wbSrc       = rvPkg::wbSrcT'(stim[base+4][1:0]);
        wbFunct3    = stim[base+5][rvPkg::Funct3W-1:0];
        wbAluResult = stim[base+6];
        wbMemData   = stim[base+7];
        wbPc4       = stim[base+8];
    endtask

    // Pending write only visible through the bypass here
    task automatic checkRecord(input int base);
        checkEq("rdata1", rdata1, stim[base+9]);
        checkEq("rdata2", rdata2, stim[base+10]);
        checkEq("imm32", imm32, stim[base+11]);
        checkEq("idWbSrc", {30'b0, idWbSrc}, stim[base+12]);
        checkEq("idRegWrite", {31'b0, idRegWrite}, stim[base+13]);
        checkEq("idIllegal", {31'b0, idIllegal}, stim[base+14]);
        // Fields at their RV32I positions in the applied instruction
        checkEq("rdAddr", {27'b0, rdAddr}, instField(stim[base+1], 7, 5));
        checkEq("funct3", {29'b0, funct3}, instField(stim[base+1], 12, 3));
        checkEq("rs1Addr", {27'b0, rs1Addr}, instField(stim[base+1], 15, 5));
        checkEq("rs2Addr", {27'b0, rs2Addr}, instField(stim[base+1], 20, 5));
        checkEq("funct7", {25'b0, funct7}, instField(stim[base+1], 25, 7));
    endtask

    task automatic reportTest();
        $display("Test %0d done, %0d errors", curTest, testErrors);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    initial begin
        int base;
        inst        = '0;
        wbRegWrite  = 1'b0;
        wbRdAddr    = '0;
        wbSrc       = rvPkg::WbAlu;
        wbFunct3    = '0;
        wbAluResult = '0;
        wbMemData   = '0;
        wbPc4       = '0;
        errors      = 0;
        checks      = 0;
        testErrors  = 0;
        cycles      = 0;
        curTest     = '0;
        $readmemh("dv/decodeStimulus.hex", stim);
        numRecs    = countRecords();
        cycleLimit = numRecs + ResetCycles + MarginCycles;
        if (numRecs == 0) begin
            $display("No records found in the stimulus file");
            errors++;
        end
        @(negedge rst);
        for (int r = 0; r < numRecs; r++) begin
            base = r * RecWords;
            @(posedge clk);
            #DriveDelay;
            // New test number closes the previous test
            if (stim[base] != curTest) begin
                if (r > 0) begin
                    reportTest();
                end
                curTest    = stim[base];
                testErrors = 0;
            end
            applyRecord(base);
            #SampleDelay;
            checkRecord(base);
        end
        if (numRecs > 0) begin
            reportTest();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: the run did not end within %0d cycles", cycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

// File: dv/decodeStimulus.hex
// test inst wbRegWrite wbRdAddr wbSrc wbFunct3 aluResult memData pc4
// then expected rdata1 rdata2 imm32 idWbSrc idRegWrite idIllegal
01 002080b3 0 01 0 0 deadbeef 00000000 00000000 00000000 00000000 00000000 0 1 0
01 01ef80b3 0 00 0 0 00000000 00000000 00000000 00000000 00000000 00000000 0 1 0
01 410780b3 0 00 0 0 00000000 00000000 00000000 00000000 00000000 00000000 0 1 0
02 fff10093 0 00 0 0 00000000 00000000 00000000 00000000 00000000 ffffffff 0 1 0
02 fe532c23 0 00 0 0 00000000 00000000 00000000 00000000 00000000 fffffff8 0 0 0
02 fe8388e3 0 00 0 0 00000000 00000000 00000000 00000000 00000000 fffffff0 0 0 0
02 00a490e3 0 00 0 0 00000000 00000000 00000000 00000000 00000000 00000800 0 0 0
02 800005b7 0 00 0 0 00000000 00000000 00000000 00000000 00000000 80000000 0 1 0
02 ffdff0ef 0 00 0 0 00000000 00000000 00000000 00000000 00000000 fffffffc 2 1 0
03 7ff22183 0 00 0 0 00000000 00000000 00000000 00000000 00000000 000007ff 1 1 0
03 800100e7 0 00 0 0 00000000 00000000 00000000 00000000 00000000 fffff800 2 1 0
03 002002ef 0 00 0 0 00000000 00000000 00000000 00000000 00000000 00000002 2 1 0
03 12345617 0 00 0 0 00000000 00000000 00000000 00000000 00000000 12345000 0 1 0
03 00000000 0 00 0 0 00000000 00000000 00000000 00000000 00000000 00000000 0 0 1
03 ffffffff 0 00 0 0 00000000 00000000 00000000 00000000 00000000 00000000 0 0 1
04 002080b3 1 03 0 2 12345678 aaaaaaaa 00000104 00000000 00000000 00000000 0 1 0
04 000180b3 1 04 2 0 deadbeef 55555555 00001004 12345678 00000000 00000000 0 1 0
04 004000b3 1 00 0 0 ffffffff 00000000 00000000 00000000 00001004 00000000 0 1 0
04 003000b3 0 00 0 0 00000000 00000000 00000000 00000000 12345678 00000000 0 1 0
05 004280b3 1 05 1 0 11111111 7654c3a5 22222222 ffffffa5 00001004 00000000 0 1 0
05 005300b3 1 06 1 1 11111111 7654c3a5 22222222 ffffc3a5 ffffffa5 00000000 0 1 0
05 006380b3 1 07 1 2 11111111 7654c3a5 22222222 7654c3a5 ffffc3a5 00000000 0 1 0
05 007400b3 1 08 1 3 11111111 7654c3a5 22222222 00000000 7654c3a5 00000000 0 1 0
05 008480b3 1 09 1 4 11111111 7654c3a5 22222222 000000a5 00000000 00000000 0 1 0
05 009500b3 1 0a 1 5 11111111 7654c3a5 22222222 0000c3a5 000000a5 00000000 0 1 0
05 00a580b3 1 0b 1 6 11111111 7654c3a5 22222222 00000000 0000c3a5 00000000 0 1 0
05 00b600b3 1 0c 1 7 11111111 7654c3a5 22222222 00000000 00000000 00000000 0 1 0
06 01ff80b3 1 1f 0 0 cafef00d 00000000 00000000 cafef00d cafef00d 00000000 0 1 0
06 01ff80b3 1 1f 2 0 cafef00d 00000000 00000abc 00000abc 00000abc 00000000 0 1 0
06 01ff80b3 0 1f 0 0 00000000 00000000 00000000 00000abc 00000abc 00000000 0 1 0

// File: dv/tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic rst
);

    // 100 ns period
    localparam int HalfPeriod  = 50;
    localparam int ResetCycles = 10;
    // Reset drops this long after its last edge
    localparam int ReleaseDelay = 10;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Synchronous reset held over the first edges
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #ReleaseDelay;
        rst = 1'b0;
    end

endmodule

// File: src/decodeIf.sv
`timescale 1ns/1ns

interface decodeIf;

    // Raw instruction from the IF/ID register
    logic [rvPkg::Xlen-1:0]     inst;
    // Sliced fields
    logic [rvPkg::OpcodeW-1:0]  opcode;
    logic [rvPkg::RegAddrW-1:0] rs1Addr;
    logic [rvPkg::RegAddrW-1:0] rs2Addr;
    logic [rvPkg::RegAddrW-1:0] rdAddr;
    logic [rvPkg::Funct3W-1:0]  funct3;
    logic [rvPkg::Funct7W-1:0]  funct7;
    // Immediate format picked from the opcode
    rvPkg::immFmtT              fmt;

    // Field decode side
    modport producer (
        output inst, opcode, rs1Addr, rs2Addr, rdAddr, funct3, funct7, fmt
    );

    // Immediate generator and top-level routing
    modport consumer (
        input inst, opcode, rs1Addr, rs2Addr, rdAddr, funct3, funct7, fmt
    );

endinterface

// File: src/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic                       clk,
    input  logic                       rst,
    // From IF/ID
    input  logic [rvPkg::Xlen-1:0]     inst,
    // Retiring instruction from write-back
    input  logic                       wbRegWrite,
    input  logic [rvPkg::RegAddrW-1:0] wbRdAddr,
    input  rvPkg::wbSrcT               wbSrc,
    input  logic [rvPkg::Funct3W-1:0]  wbFunct3,
    input  logic [rvPkg::Xlen-1:0]     wbAluResult,
    input  logic [rvPkg::Xlen-1:0]     wbMemData,
    input  logic [rvPkg::Xlen-1:0]     wbPc4,
    // Operands and immediate
    output logic [rvPkg::Xlen-1:0]     rdata1,
    output logic [rvPkg::Xlen-1:0]     rdata2,
    output logic [rvPkg::Xlen-1:0]     imm32,
    // Decoded fields
    output logic [rvPkg::Funct3W-1:0]  funct3,
    output logic [rvPkg::Funct7W-1:0]  funct7,
    output logic [rvPkg::RegAddrW-1:0] rs1Addr,
    output logic [rvPkg::RegAddrW-1:0] rs2Addr,
    output logic [rvPkg::RegAddrW-1:0] rdAddr,
    // Control carried down the pipe
    output rvPkg::wbSrcT               idWbSrc,
    output logic                       idRegWrite,
    output logic                       idIllegal
);

    // Write port between write-back select and the file
    logic                       wen;
    logic [rvPkg::RegAddrW-1:0] waddr;
    logic [rvPkg::Xlen-1:0]     wdata;

    decodeIf dec ();

    // ----------------------------------------------------------------------
    // Decode side
    // ----------------------------------------------------------------------

    instFieldDecode uInstFieldDecode (
        .inst     (inst),
        .dec      (dec.producer),
        .wbSrc    (idWbSrc),
        .regWrite (idRegWrite),
        .illegal  (idIllegal)
    );

    immGen uImmGen (
        .dec   (dec.consumer),
        .imm32 (imm32)
    );

    // Fields out to ID/EX
    assign funct3  = dec.funct3;
    assign funct7  = dec.funct7;
    assign rs1Addr = dec.rs1Addr;
    assign rs2Addr = dec.rs2Addr;
    assign rdAddr  = dec.rdAddr;

    // ----------------------------------------------------------------------
    // Register file and write-back
    // ----------------------------------------------------------------------

    writebackSelect uWritebackSelect (
        .regWrite  (wbRegWrite),
        .rdAddr    (wbRdAddr),
        .src       (wbSrc),
        .funct3    (wbFunct3),
        .aluResult (wbAluResult),
        .memData   (wbMemData),
        .pc4       (wbPc4),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata)
    );

    regFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec.rs1Addr),
        .raddr2 (dec.rs2Addr),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

// File: src/immGen.sv
`timescale 1ns/1ns

module immGen (
    decodeIf.consumer              dec,
    output logic [rvPkg::Xlen-1:0] imm32
);

    // Sign bit of every RV32I immediate
    logic sign;

    assign sign = dec.inst[31];

    // ----------------------------------------------------------------------
    // Immediate assembly per format
    // ----------------------------------------------------------------------

    always_comb begin
        case (dec.fmt)
            rvPkg::FmtI: begin
                // inst[31:20]
                imm32 = {{(rvPkg::Xlen-12){sign}}, dec.inst[31:20]};
            end
            rvPkg::FmtS: begin
                // Split around the rd slot
                imm32 = {{(rvPkg::Xlen-12){sign}}, dec.inst[31:25], dec.inst[11:7]};
            end
            rvPkg::FmtB: begin
                // Halfword offset, bit 0 always zero
                imm32 = {{(rvPkg::Xlen-13){sign}}, sign, dec.inst[7],
                         dec.inst[30:25], dec.inst[11:8], 1'b0};
            end
            rvPkg::FmtU: begin
                // Upper 20 bits, low 12 cleared
                imm32 = {dec.inst[31:12], 12'b0};
            end
            rvPkg::FmtJ: begin
                // 21-bit jump offset
                imm32 = {{(rvPkg::Xlen-21){sign}}, sign, dec.inst[19:12],
                         dec.inst[20], dec.inst[30:21], 1'b0};
            end
            default: begin
                // R format has no immediate
                imm32 = '0;
            end
        endcase
    end

endmodule

// File: src/instFieldDecode.sv
`timescale 1ns/1ns

module instFieldDecode (
    input  logic [rvPkg::Xlen-1:0] inst,
    decodeIf.producer              dec,
    output rvPkg::wbSrcT           wbSrc,
    output logic                   regWrite,
    output logic                   illegal
);

    // ----------------------------------------------------------------------
    // Field slicing
    // ----------------------------------------------------------------------

    assign dec.inst    = inst;
    assign dec.opcode  = inst[6:0];
    assign dec.rdAddr  = inst[11:7];
    assign dec.funct3  = inst[14:12];
    assign dec.rs1Addr = inst[19:15];
    assign dec.rs2Addr = inst[24:20];
    assign dec.funct7  = inst[31:25];

    // ----------------------------------------------------------------------
    // Format and write-back control
    // ----------------------------------------------------------------------

    always_comb begin
        // Defaults match a plain ALU op
        dec.fmt  = rvPkg::FmtR;
        wbSrc    = rvPkg::WbAlu;
        regWrite = 1'b1;
        illegal  = 1'b0;
        case (dec.opcode)
            rvPkg::OpLoad: begin
                dec.fmt = rvPkg::FmtI;
                wbSrc   = rvPkg::WbMem;
            end
            rvPkg::OpStore: begin
                // No destination register
                dec.fmt  = rvPkg::FmtS;
                regWrite = 1'b0;
            end
            rvPkg::OpBranch: begin
                dec.fmt  = rvPkg::FmtB;
                regWrite = 1'b0;
            end
            rvPkg::OpJal: begin
                dec.fmt = rvPkg::FmtJ;
                wbSrc   = rvPkg::WbPc4;
            end
            rvPkg::OpJalr: begin
                // Link address still goes to rd
                dec.fmt = rvPkg::FmtI;
                wbSrc   = rvPkg::WbPc4;
            end
            rvPkg::OpLui, rvPkg::OpAuipc: begin
                dec.fmt = rvPkg::FmtU;
            end
            rvPkg::OpImm: begin
                dec.fmt = rvPkg::FmtI;
            end
            rvPkg::OpReg: begin
                dec.fmt = rvPkg::FmtR;
            end
            default: begin
                // Unknown opcode, suppress any write
                regWrite = 1'b0;
                illegal  = 1'b1;
            end
        endcase
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rvPkg::RegAddrW-1:0] raddr1,
    input  logic [rvPkg::RegAddrW-1:0] raddr2,
    input  logic                       wen,
    input  logic [rvPkg::RegAddrW-1:0] waddr,
    input  logic [rvPkg::Xlen-1:0]     wdata,
    output logic [rvPkg::Xlen-1:0]     rdata1,
    output logic [rvPkg::Xlen-1:0]     rdata2
);

    // x1..x31 only, x0 is hardwired
    logic [rvPkg::Xlen-1:0] regs [1:rvPkg::NumRegs-1];

    // Write to a real register this cycle
    logic doWrite;

    assign doWrite = wen && (waddr != '0);

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            // Clear the whole file, drop any write
            for (int i = 1; i < rvPkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[waddr] <= wdata;
        end
    end

    // ----------------------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------------------

    // x0 reads zero, a matching write bypasses the array
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else if (doWrite && (waddr == raddr1)) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else if (doWrite && (waddr == raddr2)) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// File: src/rvPkg.sv
package rvPkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------

    // Data path width
    localparam int Xlen = 32;
    // Register address width
    localparam int RegAddrW = 5;
    // Architectural register count, x0 included
    localparam int NumRegs = 32;
    // Instruction field widths
    localparam int OpcodeW = 7;
    localparam int Funct3W = 3;
    localparam int Funct7W = 7;

    // ----------------------------------------------------------------------
    // RV32I base opcodes
    // ----------------------------------------------------------------------

    // Loads, I format
    localparam logic [OpcodeW-1:0] OpLoad   = 7'b0000011;
    // Stores, S format
    localparam logic [OpcodeW-1:0] OpStore  = 7'b0100011;
    // Conditional branches, B format
    localparam logic [OpcodeW-1:0] OpBranch = 7'b1100011;
    // Jumps
    localparam logic [OpcodeW-1:0] OpJal    = 7'b1101111;
    localparam logic [OpcodeW-1:0] OpJalr   = 7'b1100111;
    // Upper immediates, result comes back from the ALU
    localparam logic [OpcodeW-1:0] OpLui    = 7'b0110111;
    localparam logic [OpcodeW-1:0] OpAuipc  = 7'b0010111;
    // Register-immediate and register-register ALU ops
    localparam logic [OpcodeW-1:0] OpImm    = 7'b0010011;
    localparam logic [OpcodeW-1:0] OpReg    = 7'b0110011;

    // ----------------------------------------------------------------------
    // Load funct3 codes
    // ----------------------------------------------------------------------

    localparam logic [Funct3W-1:0] LdB  = 3'b000;
    localparam logic [Funct3W-1:0] LdH  = 3'b001;
    localparam logic [Funct3W-1:0] LdW  = 3'b010;
    // Unsigned variants
    localparam logic [Funct3W-1:0] LdBu = 3'b100;
    localparam logic [Funct3W-1:0] LdHu = 3'b101;

    // ----------------------------------------------------------------------
    // Decode types
    // ----------------------------------------------------------------------

    // Immediate format of the instruction, R carries no immediate
    typedef enum logic [2:0] {
        FmtR,
        FmtI,
        FmtS,
        FmtB,
        FmtU,
        FmtJ
    } immFmtT;

    // Source of the value written back to rd
    typedef enum logic [1:0] {
        WbAlu, // ALU result, also LUI and AUIPC
        WbMem, // Extended load data
        WbPc4  // Link address for JAL and JALR
    } wbSrcT;

endpackage

// File: src/writebackSelect.sv
`timescale 1ns/1ns

module writebackSelect (
    input  logic                       regWrite,
    input  logic [rvPkg::RegAddrW-1:0] rdAddr,
    input  rvPkg::wbSrcT               src,
    input  logic [rvPkg::Funct3W-1:0]  funct3,
    input  logic [rvPkg::Xlen-1:0]     aluResult,
    input  logic [rvPkg::Xlen-1:0]     memData,
    input  logic [rvPkg::Xlen-1:0]     pc4,
    output logic                       wen,
    output logic [rvPkg::RegAddrW-1:0] waddr,
    output logic [rvPkg::Xlen-1:0]     wdata
);

    // Load data after size and sign handling
    logic [rvPkg::Xlen-1:0] loadData;

    // Destination and enable come from the retiring instruction
    assign wen   = regWrite;
    assign waddr = rdAddr;

    // ----------------------------------------------------------------------
    // Load extension
    // ----------------------------------------------------------------------

    always_comb begin
        case (funct3)
            rvPkg::LdB:  loadData = {{(rvPkg::Xlen-8){memData[7]}}, memData[7:0]};
            // Halfword sign comes from bit 15
            rvPkg::LdH:  loadData = {{(rvPkg::Xlen-16){memData[15]}}, memData[15:0]};
            rvPkg::LdW:  loadData = memData;
            rvPkg::LdBu: loadData = {{(rvPkg::Xlen-8){1'b0}}, memData[7:0]};
            rvPkg::LdHu: loadData = {{(rvPkg::Xlen-16){1'b0}}, memData[15:0]};
            // Reserved codes
            default:     loadData = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Result source select
    // ----------------------------------------------------------------------

    always_comb begin
        case (src)
            rvPkg::WbMem: wdata = loadData;
            rvPkg::WbPc4: wdata = pc4;
            // ALU result, also the unused encoding
            default:      wdata = aluResult;
        endcase
    end

endmodule
